// ==== src/mul_params.svh ====
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// **************************************************
// multiplier sizing
// **************************************************

// operand width of the core
`define MUL_XLEN 64

// low half used by the w-type multiply
`define MUL_WLEN 32

// radix-4 steps, two multiplier bits each
// full mode: 66 extended bits -> 33 steps
`define MUL_STEPS_D 33
// word mode: 34 bits -> 17 steps
`define MUL_STEPS_W 17

// step counter must hold MUL_STEPS_D
`define MUL_CNT_W 6

`endif

// ==== src/mul_pkg.sv ====
`default_nettype none

`include "mul_params.svh"

package mul_pkg;

	// **************************************************
	// request / result types
	// **************************************************

	// signedness of the two operands
	// a unsigned with b signed is not a legal code, handled as unsigned x unsigned
	typedef struct packed {
		logic a_signed;
		logic b_signed;
	} mul_sign_t;

	// one multiply request
	typedef struct packed {
		logic                 mulw;  // 32-bit word multiply
		mul_sign_t            sign;
		logic [`MUL_XLEN-1:0] a;     // multiplicand
		logic [`MUL_XLEN-1:0] b;     // multiplier
	} mul_req_t;

	// 128-bit product, split in halves
	typedef struct packed {
		logic [`MUL_XLEN-1:0] hi;
		logic [`MUL_XLEN-1:0] lo;
	} mul_res_t;

	// **************************************************
	// controller state
	// **************************************************

	// idle: waiting for a request
	// load: operands extended into the datapath
	// step: one booth step per cycle
	// hold: result on the port until taken
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_LOAD = 2'd1,
		ST_STEP = 2'd2,
		ST_HOLD = 2'd3
	} mul_state_e;

endpackage

`default_nettype wire

// ==== src/mul_ctrl.sv ====
`default_nettype none

`include "mul_params.svh"

module mul_ctrl import mul_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire        flush,
	// request side
	input  wire        req_valid,
	output logic       req_ready,
	// from the step counter
	input  wire        last_step,
	// result side
	input  wire        res_ready,
	output logic       res_valid,
	// shared with counter and datapath
	output mul_state_e state
);

	mul_state_e state_n;

	// **************************************************
	// next state
	// **************************************************

	always_comb begin
		state_n = state;
		unique case (state)
			ST_IDLE: begin
				// handshake, req_ready is high here
				if (req_valid)
					state_n = ST_LOAD;
			end
			ST_LOAD: begin
				// single cycle of operand setup
				state_n = ST_STEP;
			end
			ST_STEP: begin
				// leave after the final booth step
				if (last_step)
					state_n = ST_HOLD;
			end
			ST_HOLD: begin
				// wait for the consumer
				if (res_ready)
					state_n = ST_IDLE;
			end
			default: begin
				state_n = ST_IDLE;
			end
		endcase

		// flush drops whatever is in flight or held
		// in idle there is nothing to drop
		if (flush && state != ST_IDLE)
			state_n = ST_IDLE;
	end

	// **************************************************
	// state register
	// **************************************************

	always_ff @(posedge clk) begin
		if (rst)
			state <= ST_IDLE;
		else
			state <= state_n;
	end

	// handshake flags straight from the state
	// one multiply at a time, so ready only when idle
	assign req_ready = (state == ST_IDLE);

	// result valid for the whole hold phase
	assign res_valid = (state == ST_HOLD);

endmodule

`default_nettype wire

// ==== src/mul_step_counter.sv ====
`default_nettype none

`include "mul_params.svh"

module mul_step_counter import mul_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire        mul_state_e state,
	input  wire        word_mode,
	output logic       last_step
);

	// remaining booth steps
	logic [`MUL_CNT_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (state == ST_LOAD) begin
			// word mode needs only half the steps
			if (word_mode)
				cnt <= `MUL_CNT_W'(`MUL_STEPS_W);
			else
				cnt <= `MUL_CNT_W'(`MUL_STEPS_D);
		end else if (state == ST_STEP) begin
			// one step consumed per cycle
			cnt <= cnt - 1'b1;
		end
	end

	// ctrl moves to hold on the edge where one step is left
	assign last_step = (cnt == `MUL_CNT_W'(1));

endmodule

`default_nettype wire

// ==== src/booth_datapath.sv ====
`default_nettype none

`include "mul_params.svh"

module booth_datapath import mul_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire        mul_state_e state,
	input  wire        req_valid,
	input  wire        mul_req_t req,
	output logic       word_mode,
	output mul_res_t   res
);

	// extended operand width, 64 bits plus room for sign and booth pairs
	localparam int OPW   = `MUL_XLEN + 2;
	// accumulator high part, two guard bits for +-2a
	localparam int ACCW  = OPW + 2;
	// position of the word product in acc_lo after the word steps
	localparam int WBASE = OPW - 2 * `MUL_STEPS_W;

	// captured request
	mul_sign_t            sign_q;
	logic [`MUL_XLEN-1:0] a_q;
	logic [`MUL_XLEN-1:0] b_q;
	logic                 a_sx;
	logic                 b_sx;

	// booth state
	logic [OPW-1:0]       mcand;
	logic [ACCW-1:0]      acc_hi;
	logic [OPW-1:0]       acc_lo;
	logic                 prev;

	// step logic
	logic [ACCW-1:0]      mcand_x;
	logic [ACCW-1:0]      pp;
	logic [ACCW-1:0]      sum;
	logic [ACCW-1:0]      hi_n;
	logic [OPW-1:0]       lo_n;
	logic [`MUL_WLEN-1:0] wprod;
	mul_res_t             res_n;

	// sign or zero extension to OPW bits
	// word mode looks at the low half only
	function automatic logic [OPW-1:0] extend(input logic [`MUL_XLEN-1:0] v,
			input logic word, input logic sx);
		logic fill;
		logic [OPW-1:0] r;
		if (word) begin
			fill = sx & v[`MUL_WLEN-1];
			r = {{(OPW-`MUL_WLEN){fill}}, v[`MUL_WLEN-1:0]};
		end else begin
			fill = sx & v[`MUL_XLEN-1];
			r = {{(OPW-`MUL_XLEN){fill}}, v};
		end
		return r;
	endfunction

	// **************************************************
	// request capture
	// **************************************************

	// mode bit goes to the step counter
	always_ff @(posedge clk) begin
		if (rst)
			word_mode <= 1'b0;
		else if (state == ST_IDLE && req_valid)
			word_mode <= req.mulw;
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && req_valid) begin
			sign_q <= req.sign;
			a_q    <= req.a;
			b_q    <= req.b;
		end
	end

	// signed b alone is not a legal code, treated as unsigned
	assign a_sx = sign_q.a_signed;
	assign b_sx = sign_q.a_signed & sign_q.b_signed;

	// **************************************************
	// radix-4 recoding and accumulate
	// **************************************************

	always_comb begin
		mcand_x = {{(ACCW-OPW){mcand[OPW-1]}}, mcand};
		// {b[i+1], b[i], b[i-1]} picks the partial product
		unique case ({acc_lo[1:0], prev})
			3'b001, 3'b010: pp = mcand_x;
			3'b011:         pp = mcand_x << 1;
			3'b100:         pp = -(mcand_x << 1);
			3'b101, 3'b110: pp = -mcand_x;
			default:        pp = '0;
		endcase
		sum  = acc_hi + pp;
		// arithmetic shift of {sum, acc_lo} by two
		hi_n = {{2{sum[ACCW-1]}}, sum[ACCW-1:2]};
		lo_n = {sum[1:0], acc_lo[OPW-1:2]};
	end

	// **************************************************
	// result formatting
	// **************************************************

	always_comb begin
		// low 32 product bits after the word steps
		wprod = lo_n[WBASE +: `MUL_WLEN];
		if (word_mode) begin
			res_n.lo = {{(`MUL_XLEN-`MUL_WLEN){wprod[`MUL_WLEN-1]}}, wprod};
			res_n.hi = {`MUL_XLEN{wprod[`MUL_WLEN-1]}};
		end else begin
			// full product is {hi_n, lo_n}, keep the low 128 bits
			res_n.lo = lo_n[`MUL_XLEN-1:0];
			res_n.hi = {hi_n[2*`MUL_XLEN-OPW-1:0], lo_n[OPW-1:`MUL_XLEN]};
		end
	end

	// **************************************************
	// load / step registers
	// **************************************************

	always_ff @(posedge clk) begin
		case (state)
			ST_LOAD: begin
				mcand  <= extend(a_q, word_mode, a_sx);
				acc_hi <= '0;
				acc_lo <= extend(b_q, word_mode, b_sx);
				prev   <= 1'b0;
			end
			ST_STEP: begin
				acc_hi <= hi_n;
				acc_lo <= lo_n;
				prev   <= acc_lo[1];
				// last write lands on the step -> hold edge
				res    <= res_n;
			end
			default: begin
				// idle and hold keep everything
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== src/mul_unit.sv ====
`default_nettype none

`include "mul_params.svh"

module mul_unit import mul_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire        flush,
	// request
	input  wire        req_valid,
	output logic       req_ready,
	input  wire        mul_req_t req,
	// result
	output logic       res_valid,
	input  wire        res_ready,
	output mul_res_t   res
);

	// **************************************************
	// internal wiring
	// **************************************************

	mul_state_e state;
	logic       last_step;
	logic       word_mode;

	// sequencing
	mul_ctrl ctrl_i (
		.clk       (clk),
		.rst       (rst),
		.flush     (flush),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.last_step (last_step),
		.res_ready (res_ready),
		.res_valid (res_valid),
		.state     (state)
	);

	// step count, loaded per request
	mul_step_counter cnt_i (
		.clk       (clk),
		.rst       (rst),
		.state     (state),
		.word_mode (word_mode),
		.last_step (last_step)
	);

	// booth arithmetic and result register
	booth_datapath dp_i (
		.clk       (clk),
		.rst       (rst),
		.state     (state),
		.req_valid (req_valid),
		.req       (req),
		.word_mode (word_mode),
		.res       (res)
	);

endmodule

`default_nettype wire

// ==== bench/mul_checker.sv ====
`default_nettype none

module mul_checker import mul_pkg::*; (
	input  wire       clk,
	input  wire       rst,
	input  wire       flush,
	input  wire       req_valid,
	input  wire       req_ready,
	input  wire       mul_req_t req,
	input  wire       res_valid,
	input  wire       res_ready,
	input  wire       mul_res_t res,
	input  wire       end_run,
	output int        errors
);
	timeunit 1ns;
	timeprecision 1ps;

	// accept edge to res_valid rise, in cycles
	localparam int LAT_FULL = 34;
	localparam int LAT_WORD = 18;

	// expected results in file order, flushed lines left out
	mul_res_t exp_q[$];
	int       num_q[$];

	int       cyc = 0;
	int       acc_cyc = 0;
	logic     acc_word = 1'b0;
	logic     pending = 1'b0;
	logic     valid_q = 1'b0;
	logic     end_done = 1'b0;
	mul_res_t held;

	// **************************************************
	// expected values from the case file
	// **************************************************

	initial begin
		int fd;
		int n;
		int num;
		int mulw;
		int a_s;
		int b_s;
		int fdly;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] hi;
		logic [63:0] lo;
		string line;
		errors = 0;
		num = 0;
		fd = $fopen("bench/mul_cases.txt", "r");
		while (fd != 0 && $fgets(line, fd) != 0) begin
			n = $sscanf(line, "%d %d %d %h %h %d %h %h", mulw, a_s, b_s, a, b, fdly, hi, lo);
			// comments and blank lines carry no case
			if (line[0] == "#" || n != 8)
				continue;
			num++;
			if (fdly == 0) begin
				exp_q.push_back({hi, lo});
				num_q.push_back(num);
			end
		end
		if (fd != 0)
			$fclose(fd);
	end

	// **************************************************
	// port monitor
	// **************************************************

	always @(posedge clk) begin
		mul_res_t expv;
		int num;
		if (rst) begin
			valid_q = 1'b0;
			pending = 1'b0;
		end else begin
			cyc++;
			// one multiply at a time
			if (res_valid && req_ready) begin
				$display("%0t: req_ready was high while a result was held", $time);
				errors++;
			end
			// stalled result must stay put
			if (res_valid && valid_q && res !== held) begin
				$display("[FAIL] %0t: result changed while waiting for res_ready", $time);
				errors++;
			end
			// latency measured on the rising edge of res_valid
			if (res_valid && !valid_q) begin
				if (!pending) begin
					$display("%0t: res_valid rose with no request in flight", $time);
					errors++;
				end else if (cyc - 1 - acc_cyc != (acc_word ? LAT_WORD : LAT_FULL)) begin
					$display("[FAIL] %0t: latency %0d cycles, expected %0d", $time,
						cyc - 1 - acc_cyc, acc_word ? LAT_WORD : LAT_FULL);
					errors++;
				end
			end
			// flush on the same edge discards the result
			if (res_valid && res_ready && !flush) begin
				if (exp_q.size() == 0) begin
					$display("%0t: a result arrived when none was expected", $time);
					errors++;
				end else begin
					expv = exp_q.pop_front();
					num = num_q.pop_front();
					if (res !== expv) begin
						$display("[FAIL] %0t: case %0d expected %h_%h, got %h_%h", $time,
							num, expv.hi, expv.lo, res.hi, res.lo);
						errors++;
					end
				end
			end
			if (flush || (res_valid && res_ready))
				pending = 1'b0;
			if (req_valid && req_ready) begin
				pending = 1'b1;
				acc_cyc = cyc;
				acc_word = req.mulw;
			end
			valid_q = res_valid;
			held = res;
			// anything still queued never showed up
			if (end_run && !end_done) begin
				end_done = 1'b1;
				if (exp_q.size() != 0) begin
					$display("%0d expected results never arrived", exp_q.size());
					errors += exp_q.size();
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_mul_unit.sv ====
`default_nettype none

module tb_mul_unit import mul_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam real DRIVE_DLY   = 0.5;
	localparam int  REQ_TIMEOUT = 50;
	localparam int  RES_TIMEOUT = 400;
	// first cases run with res_ready held high
	localparam int  CALM_CASES  = 4;

	logic        clk;
	logic        rst;
	logic        flush;
	logic        req_valid;
	logic        req_ready;
	mul_req_t    req;
	logic        res_valid;
	logic        res_ready;
	mul_res_t    res;
	logic        end_run;
	logic        stall_en;
	logic        aborted;
	logic [31:0] lfsr;
	int          chk_errors;
	int          bench_errors;

	mul_unit mul_unit_i (.*);

	mul_checker mul_checker_i (.errors(chk_errors), .*);

	// 4 ns period
	always #2 clk = ~clk;

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] r;
		r = s >> 1;
		if (s[0])
			r = r ^ 32'h80200003;
		return r;
	endfunction

	// **************************************************
	// cycle stepping and handshake waits
	// **************************************************

	// inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#(DRIVE_DLY);
		if (stall_en) begin
			// one lfsr bit per cycle
			res_ready = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end else begin
			res_ready = 1'b1;
		end
	endtask

	task automatic wait_accept(input int num);
		int n;
		logic hs;
		n = 0;
		hs = 1'b0;
		while (!hs && !aborted) begin
			hs = req_ready;
			next_cycle();
			n++;
			if (!hs && n >= REQ_TIMEOUT) begin
				$display("case %0d: request not accepted within %0d cycles", num, REQ_TIMEOUT);
				bench_errors++;
				aborted = 1'b1;
			end
		end
		req_valid = 1'b0;
	endtask

	task automatic wait_result(input int num);
		int n;
		logic got;
		n = 0;
		got = 1'b0;
		while (!got && !aborted) begin
			got = res_valid && res_ready;
			next_cycle();
			n++;
			if (!got && n >= RES_TIMEOUT) begin
				$display("case %0d: no result within %0d cycles", num, RES_TIMEOUT);
				bench_errors++;
				aborted = 1'b1;
			end
		end
	endtask

	// **************************************************
	// file-driven stimulus
	// **************************************************

	initial begin
		int fd;
		int n;
		int num;
		int mulw;
		int a_s;
		int b_s;
		int fdly;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] hi;
		logic [63:0] lo;
		string line;
		clk = 1'b0;
		rst = 1'b1;
		flush = 1'b0;
		req_valid = 1'b0;
		req = '0;
		res_ready = 1'b1;
		end_run = 1'b0;
		stall_en = 1'b0;
		aborted = 1'b0;
		lfsr = 32'd30;
		bench_errors = 0;
		num = 0;
		repeat (8) next_cycle();
		rst = 1'b0;
		fd = $fopen("bench/mul_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/mul_cases.txt");
			bench_errors++;
			aborted = 1'b1;
		end
		while (!aborted && $fgets(line, fd) != 0) begin
			if (line[0] == "#" || line.len() < 2)
				continue;
			n = $sscanf(line, "%d %d %d %h %h %d %h %h", mulw, a_s, b_s, a, b, fdly, hi, lo);
			if (n != 8) begin
				$display("malformed line in case file: %s", line);
				bench_errors++;
				continue;
			end
			num++;
			stall_en = (num > CALM_CASES);
			req.mulw = mulw[0];
			req.sign.a_signed = a_s[0];
			req.sign.b_signed = b_s[0];
			req.a = a;
			req.b = b;
			req_valid = 1'b1;
			wait_accept(num);
			if (fdly != 0) begin
				// flush sampled fdly edges after the accept edge
				repeat (fdly - 1) next_cycle();
				flush = 1'b1;
				next_cycle();
				flush = 1'b0;
			end else begin
				wait_result(num);
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (num == 0 && !aborted) begin
			$display("no cases were read from the case file");
			bench_errors++;
		end
		// let the checker count what is still outstanding
		end_run = 1'b1;
		repeat (2) next_cycle();
		$display("errors: %0d (checker %0d, bench %0d)", chk_errors + bench_errors,
			chk_errors, bench_errors);
		if (chk_errors + bench_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/mul_cases.txt ====
# mulw a_signed b_signed a b flush_delay expected_hi expected_lo
# a, b and results in hex; flush_delay in cycles after accept, 0 means no flush
# latency cases, res_ready held high
0 1 1 0000000000000003 0000000000000005 0 0000000000000000 000000000000000f
1 1 1 deadbeef00000003 cafebabe00000005 0 0000000000000000 000000000000000f
0 1 1 ffffffffffffffff ffffffffffffffff 0 0000000000000000 0000000000000001
1 1 1 5a5a5a5afffffffd a5a5a5a500000007 0 ffffffffffffffff ffffffffffffffeb
# signed x signed, full width
0 1 1 ffffffffffffffff 0000000000000002 0 ffffffffffffffff fffffffffffffffe
0 1 1 8000000000000000 8000000000000000 0 4000000000000000 0000000000000000
0 1 1 8000000000000000 ffffffffffffffff 0 0000000000000000 8000000000000000
0 1 1 0000000100000000 0000000100000000 0 0000000000000001 0000000000000000
0 1 1 7fffffffffffffff 7fffffffffffffff 0 3fffffffffffffff 0000000000000001
0 1 1 123456789abcdef0 0000000000000010 0 0000000000000001 23456789abcdef00
0 1 1 fffffffffffffffd 0000000000000007 0 ffffffffffffffff ffffffffffffffeb
# unsigned x unsigned, the last line carries the illegal code 01
0 0 0 ffffffffffffffff ffffffffffffffff 0 fffffffffffffffe 0000000000000001
0 0 0 ffffffffffffffff 0000000000000002 0 0000000000000001 fffffffffffffffe
0 0 0 8000000000000000 0000000000000003 0 0000000000000001 8000000000000000
0 0 1 ffffffffffffffff ffffffffffffffff 0 fffffffffffffffe 0000000000000001
# signed x unsigned
0 1 0 ffffffffffffffff ffffffffffffffff 0 ffffffffffffffff 0000000000000001
0 1 0 0000000000000002 8000000000000000 0 0000000000000001 0000000000000000
0 1 0 fffffffffffffffe 8000000000000000 0 ffffffffffffffff 0000000000000000
# word mode, upper operand halves are garbage
1 1 1 12345678ffffffff 87654321ffffffff 0 0000000000000000 0000000000000001
1 1 1 ffff000000010000 1111111100008000 0 ffffffffffffffff ffffffff80000000
1 0 0 00000001ffffffff fedcba98ffffffff 0 0000000000000000 0000000000000001
1 1 0 7777777fffffffff 0000000080000000 0 ffffffffffffffff ffffffff80000000
# flushed requests, each followed by a normal one
0 1 1 0000000000000003 0000000000000005 1 0000000000000000 000000000000000f
0 1 1 ffffffffffffffff 0000000000000002 0 ffffffffffffffff fffffffffffffffe
0 0 0 ffffffffffffffff ffffffffffffffff 10 fffffffffffffffe 0000000000000001
0 1 1 7fffffffffffffff 7fffffffffffffff 0 3fffffffffffffff 0000000000000001
1 1 1 5a5a5a5afffffffd a5a5a5a500000007 17 ffffffffffffffff ffffffffffffffeb
1 1 1 deadbeef00000003 cafebabe00000005 0 0000000000000000 000000000000000f
0 1 0 fffffffffffffffe 8000000000000000 33 ffffffffffffffff 0000000000000000
0 1 1 8000000000000000 8000000000000000 0 4000000000000000 0000000000000000

// ==== flist.f ====
+incdir+src
src/mul_pkg.sv
src/mul_ctrl.sv
src/mul_step_counter.sv
src/booth_datapath.sv
src/mul_unit.sv
bench/mul_checker.sv
bench/tb_mul_unit.sv

// ==== Bender.yml ====
package:
  name: mul_unit

sources:
  - include_dirs:
      - src
    files:
      - src/mul_pkg.sv
      - src/mul_ctrl.sv
      - src/mul_step_counter.sv
      - src/booth_datapath.sv
      - src/mul_unit.sv
  - target: test
    files:
      - bench/mul_checker.sv
      - bench/tb_mul_unit.sv
